// ==== Makefile ====
TOP = psgWave_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f psgWave.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -Mdir obj_dir -f psgWave.f
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "No errors" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== psgBusArb.sv ====
`timescale 1ns/1ps

module psgBusArb #(
	parameter int NumChannels = 8
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic busFree,
	input logic [NumChannels-1:0] req,
	output logic [NumChannels-1:0] sel,
	output psgPkg::chanIdT seln
);
	import psgPkg::*;

	logic [NumChannels-1:0] nextSel;
	chanIdT nextSeln;
	logic anyReq;

	// lowest numbered requester wins
	// scan from the top so the last hit is the lowest index
	always_comb begin
		nextSel = '0;
		nextSeln = '0;
		for (int i = NumChannels - 1; i >= 0; i--) begin
			if (req[i]) begin
				nextSel = '0;
				nextSel[i] = 1'b1;
				nextSeln = chanIdT'(i);
			end
		end
	end

	assign anyReq = |req;

	// ====================
	// grant register
	// ====================

	// nobody asking keeps the previous owner
	always_ff @(posedge clk) begin
		if (rst) begin
			sel <= '0;
			seln <= '0;
		end else if (ce && busFree && anyReq) begin
			sel <= nextSel;
			seln <= nextSeln;
		end
	end

	// at most one owner at a time
	assert property (@(posedge clk) disable iff (rst)
		$onehot0(sel));

	// the number and the one-hot vector name the same channel
	assert property (@(posedge clk) disable iff (rst)
		(sel != '0) |-> sel[seln]);

	// grant frozen while the bus is busy or the clock enable is low
	assert property (@(posedge clk) disable iff (rst)
		(!ce || !busFree) |=> ($stable(sel) && $stable(seln)));

endmodule

// ==== psgBusIf.sv ====
`timescale 1ns/1ps

module psgBusIf #(
	parameter int NumChannels = 8,
	parameter int TableLen = 16
) (
	input logic clk,
	input logic rst,
	input logic [NumChannels-1:0] req,
	input logic [NumChannels-1:0] sel,
	input psgPkg::chanIdT seln,
	input psgPkg::addrT [NumChannels-1:0] chanAddr,
	output logic busFree,
	output logic sysReq,
	output psgPkg::addrT sysAddr,
	input logic sysAck,
	input psgPkg::sampleT sysData,
	output logic fill,
	output psgPkg::sampleT fillData
);
	import psgPkg::*;

	busStateT state;
	logic [NumChannels-1:0] lowerMask;
	logic grantReq;
	logic lowerReq;
	logic startXfer;

	// all channels numbered below the current owner
	assign lowerMask = sel - NumChannels'(1);

	assign grantReq = |(req & sel);
	assign lowerReq = |(req & lowerMask);

	// start only when the owner is also the lowest requester
	// otherwise the arbiter is about to move the grant this edge
	assign startXfer = grantReq && !lowerReq;

	assign busFree = (state == busIdle);

	// ====================
	// transfer FSM
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= busIdle;
			sysReq <= 1'b0;
			fill <= 1'b0;
		end else begin
			fill <= 1'b0;
			case (state)
				busIdle: begin
					if (startXfer) begin
						state <= busWait;
						sysReq <= 1'b1;
					end
				end
				busWait: begin
					// data is sampled in the ack cycle
					if (sysAck) begin
						state <= busDone;
						sysReq <= 1'b0;
						fill <= 1'b1;
					end
				end
				busDone: begin
					state <= busIdle;
				end
				default: begin
					state <= busIdle;
				end
			endcase
		end
	end

	// address latched at the start, data at the acknowledge
	always_ff @(posedge clk) begin
		if (state == busIdle && startXfer) begin
			sysAddr <= chanAddr[seln];
		end
		if (state == busWait && sysAck) begin
			fillData <= sysData;
		end
	end

	// address held until the memory answers
	assert property (@(posedge clk) disable iff (rst)
		(sysReq && !sysAck) |=> (sysReq && $stable(sysAddr)));

	// every read falls inside the table of the channel that owns the bus
	assert property (@(posedge clk) disable iff (rst)
		sysReq |-> (int'(sysAddr) / TableLen == int'(seln)));

endmodule

// ==== psgMixer.sv ====
`timescale 1ns/1ps

module psgMixer #(
	parameter int NumChannels = 8
) (
	input logic clk,
	input logic rst,
	input logic [NumChannels-1:0] enable,
	input logic [NumChannels-1:0] sampleValid,
	input psgPkg::sampleT [NumChannels-1:0] samples,
	output logic [NumChannels-1:0] take,
	output logic outValid,
	output psgPkg::mixT outData,
	input logic outReady
);
	import psgPkg::*;

	// headroom for eight channels plus sign
	localparam int AccW = $bits(mixT) + 4;
	localparam int MixMax = 2 ** ($bits(mixT) - 1) - 1;
	localparam int MixMin = -(2 ** ($bits(mixT) - 1));

	logic signed [AccW-1:0] acc;
	mixT mixSat;
	logic allValid;
	logic canLoad;
	logic building;

	// disabled channels count as ready
	assign allValid = &(sampleValid | ~enable);
	assign canLoad = !outValid || outReady;
	assign building = |take;

	// ====================
	// frame sum
	// ====================

	// the take mask picks the channels that belong to this frame
	always_comb begin
		acc = '0;
		for (int c = 0; c < NumChannels; c++) begin
			if (take[c]) begin
				acc = acc + AccW'(signed'(samples[c]));
			end
		end
	end

	// clamp to the output range
	assign mixSat = (acc > MixMax) ? mixT'(MixMax) :
		(acc < MixMin) ? mixT'(MixMin) : mixT'(acc);

	always_ff @(posedge clk) begin
		if (rst) begin
			take <= '0;
		end else if (!building && allValid && canLoad && (|enable)) begin
			take <= enable;
		end else begin
			take <= '0;
		end
	end

	// output register
	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
		end else if (building) begin
			outValid <= 1'b1;
		end else if (outReady) begin
			outValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (building) begin
			outData <= mixSat;
		end
	end

	// a stalled frame is neither dropped nor changed
	assert property (@(posedge clk) disable iff (rst)
		(outValid && !outReady) |=> (outValid && $stable(outData)));

endmodule

// ==== psgPkg.sv ====
package psgPkg;

	// ====================
	// data widths
	// ====================

	// one wave table entry, also the width of the system bus data
	typedef logic signed [11:0] sampleT;

	// mixed output frame
	typedef logic signed [15:0] mixT;

	// system bus word address
	typedef logic [15:0] addrT;

	// channel number, enough for eight channels
	typedef logic [2:0] chanIdT;

	// ====================
	// bus interface FSM
	// ====================

	// idle is the only state in which the arbiter may move the grant
	typedef enum logic [1:0] {
		busIdle,
		busWait,
		busDone
	} busStateT;

endpackage

// ==== psgWave.f ====
psgPkg.sv
psgBusArb.sv
psgWaveChannel.sv
psgBusIf.sv
psgMixer.sv
psgWave.sv
psgWave_tb.sv

// ==== psgWave.sv ====
`timescale 1ns/1ps

module psgWave #(
	parameter int NumChannels = 8,
	parameter int TableLen = 16
) (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic [NumChannels-1:0] enable,
	output logic sysReq,
	output psgPkg::addrT sysAddr,
	input logic sysAck,
	input psgPkg::sampleT sysData,
	output logic outValid,
	output psgPkg::mixT outData,
	input logic outReady
);
	import psgPkg::*;

	logic [NumChannels-1:0] req;
	logic [NumChannels-1:0] sel;
	chanIdT seln;
	logic busFree;
	logic fill;
	sampleT fillData;
	addrT [NumChannels-1:0] chanAddr;
	logic [NumChannels-1:0] sampleValid;
	sampleT [NumChannels-1:0] samples;
	logic [NumChannels-1:0] take;

	// ====================
	// bus side
	// ====================

	psgBusArb #(
		.NumChannels(NumChannels)
	) busArb (
		.clk,
		.rst,
		.ce,
		.busFree,
		.req,
		.sel,
		.seln
	);

	psgBusIf #(
		.NumChannels(NumChannels),
		.TableLen(TableLen)
	) busIf (
		.clk,
		.rst,
		.req,
		.sel,
		.seln,
		.chanAddr,
		.busFree,
		.sysReq,
		.sysAddr,
		.sysAck,
		.sysData,
		.fill,
		.fillData
	);

	// one fetch sequencer per channel
	for (genvar c = 0; c < NumChannels; c++) begin : gChan
		psgWaveChannel #(
			.TableLen(TableLen),
			.ChannelId(c)
		) chan (
			.clk,
			.rst,
			.enable(enable[c]),
			.sel(sel[c]),
			.fill,
			.fillData,
			.take(take[c]),
			.req(req[c]),
			.addr(chanAddr[c]),
			.sampleValid(sampleValid[c]),
			.sample(samples[c])
		);
	end

	psgMixer #(
		.NumChannels(NumChannels)
	) mixer (
		.clk,
		.rst,
		.enable,
		.sampleValid,
		.samples,
		.take,
		.outValid,
		.outData,
		.outReady
	);

endmodule

// ==== psgWaveChannel.sv ====
`timescale 1ns/1ps

module psgWaveChannel #(
	parameter int TableLen = 16,
	parameter int ChannelId = 0
) (
	input logic clk,
	input logic rst,
	input logic enable,
	input logic sel,
	input logic fill,
	input psgPkg::sampleT fillData,
	input logic take,
	output logic req,
	output psgPkg::addrT addr,
	output logic sampleValid,
	output psgPkg::sampleT sample
);
	import psgPkg::*;

	localparam int IdxW = (TableLen > 1) ? $clog2(TableLen) : 1;

	// start of this channel's region in wave memory
	localparam addrT BaseAddr = addrT'(ChannelId * TableLen);

	logic [IdxW-1:0] index;
	logic accept;

	// only the granted channel takes the returned word
	assign accept = fill && sel;

	// one sample ahead, so ask only while the buffer is empty
	assign req = enable && !sampleValid;

	assign addr = BaseAddr + addrT'(index);

	// ====================
	// buffer and index
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			sampleValid <= 1'b0;
			index <= '0;
		end else if (accept) begin
			sampleValid <= 1'b1;
			// wrap at the end of the table
			if (index == IdxW'(TableLen - 1)) begin
				index <= '0;
			end else begin
				index <= index + IdxW'(1);
			end
		end else if (take) begin
			sampleValid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			sample <= fillData;
		end
	end

	// the bus interface must never deliver into a full buffer
	assert property (@(posedge clk) disable iff (rst)
		(fill && sel) |-> !sampleValid);

endmodule

// ==== psgWave_tb.sv ====
`timescale 1ns/1ps

module psgWave_tb;
	import psgPkg::*;

	localparam int NumChannels = 8;
	localparam int TableLen = 16;
	localparam int FrameTimeout = 400;

	logic clk;
	logic rst;
	logic ce;
	logic [NumChannels-1:0] enable;
	logic sysReq;
	addrT sysAddr;
	logic sysAck;
	sampleT sysData;
	logic outValid;
	mixT outData;
	logic outReady;

	sampleT mem [0:255];
	mixT frameLog [0:1023];
	int frameCount;
	int readIdx;
	int enList [NumChannels];
	int enCount;
	int readCount;
	int stallReads [NumChannels];
	int ceLowEdges;
	logic sysReqPrev;
	logic holdPending;
	mixT heldData;
	int monErrors;
	int mainErrors;
	logic timedOut;
	int seed;
	int ackDelay;
	logic ackPending;

	psgWave #(
		.NumChannels(NumChannels),
		.TableLen(TableLen)
	) i_dut (
		.clk,
		.rst,
		.ce,
		.enable,
		.sysReq,
		.sysAddr,
		.sysAck,
		.sysData,
		.outValid,
		.outData,
		.outReady
	);

	always #20 clk = ~clk;

	// ====================
	// memory model
	// ====================

	// one read at a time, answered 0 to 3 cycles after sysReq is seen
	initial begin
		sysAck = 1'b0;
		sysData = '0;
		ackPending = 1'b0;
		ackDelay = 0;
		seed = 61373;
		forever begin
			@(negedge clk);
			if (sysAck) begin
				sysAck = 1'b0;
			end else begin
				if (sysReq && !ackPending) begin
					ackPending = 1'b1;
					ackDelay = $random(seed) & 3;
				end
				if (ackPending) begin
					if (ackDelay == 0) begin
						sysAck = 1'b1;
						sysData = mem[sysAddr[7:0]];
						ackPending = 1'b0;
					end else begin
						ackDelay = ackDelay - 1;
					end
				end
			end
		end
	end

	// ====================
	// bus and output monitor
	// ====================

	always @(posedge clk) begin
		int ch;
		int expAddr;
		if (rst) begin
			frameCount = 0;
			readCount = 0;
			ceLowEdges = 0;
			sysReqPrev = 1'b0;
			holdPending = 1'b0;
			heldData = '0;
			monErrors = 0;
			for (int c = 0; c < NumChannels; c++) begin
				stallReads[c] = 0;
			end
		end else begin
			// a new read may still start just after ce falls, but not later
			if (ce) begin
				ceLowEdges = 0;
			end else begin
				ceLowEdges = ceLowEdges + 1;
			end
			if (sysReq && !sysReqPrev && ceLowEdges > 2) begin
				$display("read started %0d cycles into a ce gap at %0t", ceLowEdges, $time);
				monErrors++;
			end
			sysReqPrev = sysReq;

			if (sysReq && sysAck) begin
				// reads cycle through the enabled channels in ascending order
				if (enCount > 0) begin
					expAddr = enList[readCount % enCount] * TableLen
						+ (readCount / enCount) % TableLen;
					if (int'(sysAddr) != expAddr) begin
						$display("Mismatch at %0t: sysAddr expected %0h, got %0h",
							$time, expAddr, sysAddr);
						monErrors++;
					end
				end
				readCount++;
				ch = int'(sysAddr) / TableLen;
				if (outValid && !outReady && ch < NumChannels) begin
					stallReads[ch]++;
					if (stallReads[ch] > 1) begin
						$display("channel %0d read twice during one stall at %0t", ch, $time);
						monErrors++;
					end
				end
			end
			if (!(outValid && !outReady)) begin
				for (int c = 0; c < NumChannels; c++) begin
					stallReads[c] = 0;
				end
			end

			if (holdPending && outData !== heldData) begin
				$display("Mismatch at %0t: outData held %0d, got %0d", $time, heldData, outData);
				monErrors++;
			end
			holdPending = outValid && !outReady;
			heldData = outData;

			if (outValid && outReady && frameCount < 1024) begin
				frameLog[frameCount] = outData;
				frameCount++;
			end
		end
	end

	task automatic waitForFrame();
		int waited;
		waited = 0;
		while (frameCount <= readIdx && waited < FrameTimeout) begin
			@(negedge clk);
			waited++;
		end
		if (frameCount <= readIdx) begin
			$display("no frame %0d arrived within %0d cycles", readIdx, FrameTimeout);
			mainErrors++;
			timedOut = 1'b1;
		end
	endtask

	// ====================
	// trace player
	// ====================

	initial begin
		int fd;
		int code;
		int addrIn;
		int dataIn;
		int countIn;
		int expVal;
		logic [7:0] kind;
		logic [8*128-1:0] lineBuf;
		logic [NumChannels-1:0] maskIn;

		clk = 1'b0;
		rst = 1'b1;
		ce = 1'b1;
		enable = '0;
		outReady = 1'b1;
		mainErrors = 0;
		timedOut = 1'b0;
		readIdx = 0;
		enCount = 0;
		for (int a = 0; a < 256; a++) begin
			mem[a] = sampleT'(a);
		end

		fd = $fopen("psgWave_trace.txt", "r");
		if (fd == 0) begin
			$display("cannot open psgWave_trace.txt");
			mainErrors++;
		end
		repeat (16) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		while (fd != 0 && !timedOut) begin
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				break;
			end
			if (kind == "#") begin
				code = $fgets(lineBuf, fd);
			end else if (kind == "M") begin
				code = $fscanf(fd, "%h %h", addrIn, dataIn);
				mem[addrIn[7:0]] = sampleT'(dataIn);
			end else if (kind == "E") begin
				code = $fscanf(fd, "%h", maskIn);
				@(negedge clk);
				enable = maskIn;
				enCount = 0;
				for (int c = 0; c < NumChannels; c++) begin
					if (maskIn[c]) begin
						enList[enCount] = c;
						enCount++;
					end
				end
			end else if (kind == "G") begin
				code = $fscanf(fd, "%d", countIn);
				@(negedge clk);
				ce = 1'b0;
				repeat (countIn) @(negedge clk);
				ce = 1'b1;
			end else if (kind == "R") begin
				code = $fscanf(fd, "%d", countIn);
				@(negedge clk);
				outReady = 1'b0;
				repeat (countIn) @(negedge clk);
				outReady = 1'b1;
			end else if (kind == "F") begin
				code = $fscanf(fd, "%d", expVal);
				waitForFrame();
				if (!timedOut) begin
					if (int'(frameLog[readIdx]) != expVal) begin
						$display("Mismatch at %0t: outData frame %0d expected %0d, got %0d",
							$time, readIdx, expVal, frameLog[readIdx]);
						mainErrors++;
					end
					readIdx++;
				end
			end else begin
				$display("unknown trace line kind %s", kind);
				mainErrors++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end

		$display("checked %0d frames and %0d reads, %0d errors",
			readIdx, readCount, mainErrors + monErrors);
		if (mainErrors == 0 && monErrors == 0 && readIdx > 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

// ==== psgWave_trace.txt ====
# kinds: M addr data (hex), E enable mask (hex), G ce low cycles, R outReady low cycles
# F expected frame (signed decimal), frame n sums word 16*c+n over the enabled channels c
M 002 7ff
M 012 7ff
M 032 7ff
M 042 7ff
M 052 7ff
M 072 7ff
M 003 800
M 013 800
M 033 800
M 043 800
M 053 800
M 073 800
E bb
F 320
F 326
F 12282
G 12
F -12288
F 344
R 30
F 350
F 356
F 362
G 25
F 368
F 374
R 9
F 380
F 386
F 392
F 398
F 404
R 40
F 410
F 320
